// File: bench/fill_mem_model.sv
// ========================================
// Fill port responder for the testbench
// Address-derived lines, an error region
// and random stalls and latency
// ========================================

`default_nettype none

module fill_mem_model #(
  parameter int unsigned AW   = 32,
  parameter int unsigned LW   = 128,
  parameter int          SEED = 57152
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          req_valid_i,
  input  logic [AW-1:0] req_addr_i,
  output logic          req_ready_o,
  output logic          rsp_valid_o,
  output logic [LW-1:0] rsp_data_o,
  output logic          rsp_error_o,
  input  logic          rsp_ready_i
);

  integer        seed;
  int unsigned   now_cyc;
  int unsigned   lat;
  logic [AW-1:0] addr_q [$];
  int unsigned   due_q [$];

  // Word k of a line is its own fetch-word address XOR a fixed pattern
  function automatic logic [LW-1:0] line_for(input logic [AW-1:0] addr);
    logic [LW-1:0] line;
    logic [AW-1:0] word_addr;
    line = '0;
    for (int k = 0; k < LW / 32; k++) begin
      word_addr = {addr[AW-1:4], 4'b0000} + AW'(4 * k);
      line[k*32 +: 32] = word_addr[31:0] ^ 32'hA5A5_0000;
    end
    return line;
  endfunction

  initial begin
    seed        = SEED;
    now_cyc     = 0;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_error_o = 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_q.delete();
      due_q.delete();
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_error_o <= 1'b0;
    end else begin
      now_cyc = now_cyc + 1;
      if (rsp_valid_o && rsp_ready_i) begin
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        lat = 1 + ($unsigned($random(seed)) % 4);
        addr_q.push_back(req_addr_i);
        due_q.push_back(now_cyc + lat);
      end
      // Ready is dropped about one cycle in four
      req_ready_o <= (($random(seed) & 3) != 0);
      // Answers leave strictly in request order
      if (addr_q.size() != 0 && now_cyc >= due_q[0]) begin
        rsp_valid_o <= 1'b1;
        rsp_data_o  <= line_for(addr_q[0]);
        rsp_error_o <= addr_q[0][AW-1];
      end else begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_icache_bypass.sv
// ========================================
// Testbench for the bypass fetch path
// Table-driven fetches on three ports
// against a random-stall fill responder
// ========================================

`default_nettype none

module tb_icache_bypass;

  localparam int unsigned NR_PORTS       = 3;
  localparam int unsigned AW             = 32;
  localparam int unsigned DEPTH          = 4;
  localparam int          SEED           = 57152;
  localparam int unsigned RESET_CYCLES   = 10;
  localparam int unsigned IDLE_CYCLES    = 5;
  localparam int unsigned NUM_ROWS       = 10;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_ROWS * NR_PORTS * 16;

  logic                             clk_i;
  logic                             rst_n_i;
  logic [NR_PORTS-1:0]              inst_valid_i;
  logic [NR_PORTS-1:0][AW-1:0]      inst_addr_i;
  logic [NR_PORTS-1:0]              inst_ready_o;
  logic [NR_PORTS-1:0][31:0]        inst_data_o;
  logic [NR_PORTS-1:0]              inst_error_o;
  logic                             refill_req_valid_o;
  logic [AW-1:0]                    refill_req_addr_o;
  logic                             refill_req_ready_i;
  logic                             refill_rsp_valid_i;
  logic [127:0]                     refill_rsp_data_i;
  logic                             refill_rsp_error_i;
  logic                             refill_rsp_ready_o;

  // Stimulus table, one row of up to three concurrent fetches
  logic [NR_PORTS-1:0] tab_en   [NUM_ROWS];
  logic [AW-1:0]       tab_addr [NUM_ROWS][NR_PORTS];
  logic [31:0]         tab_data [NUM_ROWS][NR_PORTS];
  logic                tab_err  [NUM_ROWS][NR_PORTS];

  int unsigned cycle_cnt = 0;

  // Refills accepted on the request side and not yet answered
  int          outstanding = 0;

  icache_bypass_top #(
    .NR_FETCH_PORTS ( NR_PORTS ),
    .FETCH_AW       ( AW       ),
    .RSP_FIFO_DEPTH ( DEPTH    )
  ) UUT (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .inst_valid_i       ( inst_valid_i       ),
    .inst_addr_i        ( inst_addr_i        ),
    .inst_ready_o       ( inst_ready_o       ),
    .inst_data_o        ( inst_data_o        ),
    .inst_error_o       ( inst_error_o       ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_data_i  ( refill_rsp_data_i  ),
    .refill_rsp_error_i ( refill_rsp_error_i ),
    .refill_rsp_ready_o ( refill_rsp_ready_o )
  );

  fill_mem_model #(
    .AW   ( AW   ),
    .LW   ( 128  ),
    .SEED ( SEED )
  ) i_fill_mem (
    .clk_i       ( clk_i              ),
    .rst_n_i     ( rst_n_i            ),
    .req_valid_i ( refill_req_valid_o ),
    .req_addr_i  ( refill_req_addr_o  ),
    .req_ready_o ( refill_req_ready_i ),
    .rsp_valid_o ( refill_rsp_valid_i ),
    .rsp_data_o  ( refill_rsp_data_i  ),
    .rsp_error_o ( refill_rsp_error_i ),
    .rsp_ready_i ( refill_rsp_ready_o )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic add_entry(input int row, input int port, input logic [AW-1:0] addr,
                           input logic [31:0] data, input logic err);
    tab_en[row][port]   = 1'b1;
    tab_addr[row][port] = addr;
    tab_data[row][port] = data;
    tab_err[row][port]  = err;
  endtask

  task automatic build_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      tab_en[r] = '0;
    end
    // Single port, each of the four word offsets
    add_entry(0, 0, 32'h0000_1000, 32'hA5A5_1000, 1'b0);
    add_entry(1, 0, 32'h0000_1004, 32'hA5A5_1004, 1'b0);
    add_entry(2, 1, 32'h0000_2008, 32'hA5A5_2008, 1'b0);
    add_entry(3, 2, 32'h0000_300C, 32'hA5A5_300C, 1'b0);
    // All ports at once on different lines
    add_entry(4, 0, 32'h0000_4004, 32'hA5A5_4004, 1'b0);
    add_entry(4, 1, 32'h0000_5108, 32'hA5A5_5108, 1'b0);
    add_entry(4, 2, 32'h0001_600C, 32'hA5A4_600C, 1'b0);
    add_entry(5, 0, 32'h0000_700C, 32'hA5A5_700C, 1'b0);
    add_entry(5, 1, 32'h0000_7000, 32'hA5A5_7000, 1'b0);
    add_entry(5, 2, 32'h0000_8004, 32'hA5A5_8004, 1'b0);
    // Top address bit set marks the error region
    add_entry(6, 1, 32'h8000_9008, 32'h25A5_9008, 1'b1);
    add_entry(7, 0, 32'h8000_A000, 32'h25A5_A000, 1'b1);
    add_entry(7, 1, 32'h0000_B004, 32'hA5A5_B004, 1'b0);
    add_entry(7, 2, 32'hC000_C00C, 32'h65A5_C00C, 1'b1);
    add_entry(8, 0, 32'h1234_5678, 32'hB791_5678, 1'b0);
    add_entry(8, 1, 32'h0ABC_DEF4, 32'hAF19_DEF4, 1'b0);
    add_entry(8, 2, 32'hFFFF_FFFC, 32'h5A5A_FFFC, 1'b1);
    add_entry(9, 2, 32'h0000_0004, 32'hA5A5_0004, 1'b0);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the fetches did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  // Every refill goes out with the line offset cleared, and the response side
  // is ready exactly while some accepted refill is still unanswered
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding = 0;
    end else begin
      if (refill_req_valid_o) begin
        compare({28'b0, refill_req_addr_o[3:0]}, 32'b0, "refill address not line aligned");
      end
      compare({31'b0, refill_rsp_ready_o}, {31'b0, outstanding != 0},
              "fill response ready against refills in flight");
      if (refill_req_valid_o && refill_req_ready_i) begin
        outstanding = outstanding + 1;
      end
      if (refill_rsp_valid_i && refill_rsp_ready_o) begin
        outstanding = outstanding - 1;
      end
    end
  end

  initial begin
    logic [NR_PORTS-1:0] pending;
    rst_n_i      = 1'b0;
    inst_valid_i = '0;
    inst_addr_i  = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Nothing may move while no port fetches
    repeat (IDLE_CYCLES) begin
      @(posedge clk_i);
      compare({29'b0, inst_ready_o}, 32'b0, "ready before any fetch");
      compare({31'b0, refill_req_valid_o}, 32'b0, "refill request before any fetch");
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk_i);
      for (int p = 0; p < NR_PORTS; p++) begin
        if (tab_en[r][p]) begin
          inst_valid_i[p] <= 1'b1;
          inst_addr_i[p]  <= tab_addr[r][p];
        end
      end
      pending = tab_en[r];
      while (pending != '0) begin
        @(posedge clk_i);
        for (int p = 0; p < NR_PORTS; p++) begin
          if (inst_ready_o[p]) begin
            compare({31'b0, pending[p]}, 32'd1,
                    $sformatf("row %0d port %0d ready without a fetch", r, p));
            compare(inst_data_o[p], tab_data[r][p], $sformatf("row %0d port %0d data", r, p));
            compare({31'b0, inst_error_o[p]}, {31'b0, tab_err[r][p]},
                    $sformatf("row %0d port %0d error", r, p));
            pending[p] = 1'b0;
            inst_valid_i[p] <= 1'b0;
          end
        end
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the bypass fetch path testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache_bypass \
  -f src.f -o tb_icache_bypass \
  && ./obj_dir/tb_icache_bypass | tee /dev/stderr | grep -q "all tests passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// File: src.f
verilog/icache_bypass_pkg.sv
verilog/bypass_port_fsm.sv
verilog/fetch_rr_arbiter.sv
verilog/refill_rsp_router.sv
verilog/icache_bypass_top.sv
bench/fill_mem_model.sv
bench/tb_icache_bypass.sv

// File: verilog/bypass_port_fsm.sv
// ========================================
// Bypass fetch port FSM
// Turns a held fetch request into one line
// refill and returns the addressed word
// ========================================

`default_nettype none

module bypass_port_fsm #(
  parameter int unsigned FETCH_AW = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,

  // Fetch port
  input  logic                               inst_valid_i,
  input  logic [FETCH_AW-1:0]                inst_addr_i,
  output logic                               inst_ready_o,
  output logic [icache_bypass_pkg::FETCH_DW-1:0] inst_data_o,
  output logic                               inst_error_o,

  // Arbiter side
  input  logic                               rsp_full_i,
  output logic                               req_valid_o,
  input  logic                               gnt_i,

  // Routed fill response
  input  logic                               rsp_valid_i,
  input  icache_bypass_pkg::fill_line_u      rsp_line_i,
  input  logic                               rsp_error_i
);

  import icache_bypass_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Request,
    Wait,
    Present
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [WORD_SEL_W-1:0] word_idx;
  logic [FETCH_DW-1:0]   data_q;
  logic                  error_q;

  // The requester holds the address until ready, so it still selects the word
  assign word_idx = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  always_comb begin
    state_d      = state_q;
    req_valid_o  = 1'b0;
    inst_ready_o = 1'b0;
    case (state_q)
      Idle: begin
        if (inst_valid_i) begin
          state_d = Request;
        end
      end
      Request: begin
        // Only ask while the router still has room to record the grant
        req_valid_o = !rsp_full_i;
        if (gnt_i) begin
          state_d = Wait;
        end
      end
      Wait: begin
        if (rsp_valid_i) begin
          state_d = Present;
        end
      end
      Present: begin
        // Word is served from the register for exactly one cycle
        inst_ready_o = 1'b1;
        state_d      = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      data_q  <= rsp_line_i.word[word_idx];
      error_q <= rsp_error_i;
    end
  end

  assign inst_data_o  = data_q;
  assign inst_error_o = error_q;

  // The router may only steer a response here while this port waits for one
  a_rsp_only_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> state_q == Wait);

  // The arbiter may only grant a port that is still requesting
  a_gnt_only_in_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |-> state_q == Request);

endmodule

`default_nettype wire

// File: verilog/fetch_rr_arbiter.sv
// ========================================
// Round-robin refill request arbiter
// Forms line-aligned fill requests and
// reports each grant to the router
// ========================================

`default_nettype none

module fetch_rr_arbiter #(
  parameter int unsigned NR_FETCH_PORTS = 3,
  parameter int unsigned FETCH_AW       = 32
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,

  input  logic [NR_FETCH_PORTS-1:0]               req_valid_i,
  input  logic [NR_FETCH_PORTS-1:0][FETCH_AW-1:0] req_addr_i,
  output logic [NR_FETCH_PORTS-1:0]               gnt_o,

  output logic                                    refill_req_valid_o,
  output logic [FETCH_AW-1:0]                     refill_req_addr_o,
  input  logic                                    refill_req_ready_i,

  output logic                                    push_o,
  output logic [NR_FETCH_PORTS-1:0]               push_mask_o
);

  import icache_bypass_pkg::*;

  localparam int unsigned IDX_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] rr_idx;
  logic [IDX_W-1:0] winner;
  logic [IDX_W-1:0] sel_q;
  logic             locked_q;
  logic             accept;

  // Lowest-numbered requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    found  = 1'b0;
    rr_idx = ptr_q;
    for (int unsigned k = 0; k < NR_FETCH_PORTS; k++) begin
      idx = (int'(ptr_q) + k) % NR_FETCH_PORTS;
      if (!found && req_valid_i[idx]) begin
        found  = 1'b1;
        rr_idx = IDX_W'(idx);
      end
    end
  end

  // A request that saw back-pressure keeps its port until accepted
  assign winner = locked_q ? sel_q : rr_idx;

  assign refill_req_valid_o = |req_valid_i;
  assign refill_req_addr_o  = {req_addr_i[winner][FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign accept             = refill_req_valid_o && refill_req_ready_i;

  always_comb begin
    gnt_o = '0;
    if (accept) begin
      gnt_o[winner] = 1'b1;
    end
  end

  assign push_o      = accept;
  assign push_mask_o = gnt_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q    <= '0;
      sel_q    <= '0;
      locked_q <= 1'b0;
    end else begin
      locked_q <= refill_req_valid_o && !refill_req_ready_i;
      sel_q    <= winner;
      if (accept) begin
        ptr_q <= (winner == IDX_W'(NR_FETCH_PORTS - 1)) ? '0 : winner + 1'b1;
      end
    end
  end

  // A grant must reach a port that is still asking, also when the choice was locked
  a_gnt_to_requester: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_o & ~req_valid_i) == '0);

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    refill_req_valid_o && !refill_req_ready_i
      |=> refill_req_valid_o && $stable(refill_req_addr_o));

endmodule

`default_nettype wire

// File: verilog/icache_bypass_pkg.sv
// ========================================
// Instruction cache bypass fetch path
// Fixed fetch word and line geometry, and
// the two decodings of a returned line
// ========================================

`default_nettype none

package icache_bypass_pkg;

  // Width of one fetch word as seen by a fetch port
  localparam int unsigned FETCH_DW = 32;

  // Width of one line as it travels on the fill port
  localparam int unsigned LINE_WIDTH = 128;

  // Number of fetch words that make up one line
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;

  // Byte-offset bits inside a fetch word
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);

  // Byte-offset bits inside a line
  localparam int unsigned LINE_ALIGN = $clog2(LINE_WIDTH / 8);

  // Number of address bits that select a word within a line
  localparam int unsigned WORD_SEL_W = LINE_ALIGN - FETCH_ALIGN;

  // One returned line, read either as the raw fill beat or as fetch words.
  // Word k sits at bits k*FETCH_DW and up, so address bits
  // LINE_ALIGN-1 down to FETCH_ALIGN index the word view directly
  typedef union packed {
    logic [LINE_WIDTH-1:0]                   raw;
    logic [WORDS_PER_LINE-1:0][FETCH_DW-1:0] word;
  } fill_line_u;

endpackage

`default_nettype wire

// File: verilog/icache_bypass_top.sv
// ========================================
// Instruction cache bypass fetch path top
// Fetch port FSMs, refill arbiter and the
// response router on one fill port
// ========================================

`default_nettype none

module icache_bypass_top #(
  parameter int unsigned NR_FETCH_PORTS = 3,
  parameter int unsigned FETCH_AW       = 32,
  parameter int unsigned RSP_FIFO_DEPTH = 4
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,

  // Fetch ports
  input  logic [NR_FETCH_PORTS-1:0]                                inst_valid_i,
  input  logic [NR_FETCH_PORTS-1:0][FETCH_AW-1:0]                  inst_addr_i,
  output logic [NR_FETCH_PORTS-1:0]                                inst_ready_o,
  output logic [NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_DW-1:0] inst_data_o,
  output logic [NR_FETCH_PORTS-1:0]                                inst_error_o,

  // Fill request
  output logic                                                     refill_req_valid_o,
  output logic [FETCH_AW-1:0]                                      refill_req_addr_o,
  input  logic                                                     refill_req_ready_i,

  // Fill response
  input  logic                                                     refill_rsp_valid_i,
  input  logic [icache_bypass_pkg::LINE_WIDTH-1:0]                 refill_rsp_data_i,
  input  logic                                                     refill_rsp_error_i,
  output logic                                                     refill_rsp_ready_o
);

  import icache_bypass_pkg::*;

  logic [NR_FETCH_PORTS-1:0] req_valid;
  logic [NR_FETCH_PORTS-1:0] gnt;
  logic [NR_FETCH_PORTS-1:0] rsp_valid;
  logic [NR_FETCH_PORTS-1:0] push_mask;
  logic                      push;
  logic                      rsp_full;
  logic                      rsp_error;
  fill_line_u                rsp_line;

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_fsm #(
      .FETCH_AW ( FETCH_AW )
    ) i_port (
      .clk_i        ( clk_i           ),
      .rst_n_i      ( rst_n_i         ),
      .inst_valid_i ( inst_valid_i[i] ),
      .inst_addr_i  ( inst_addr_i[i]  ),
      .inst_ready_o ( inst_ready_o[i] ),
      .inst_data_o  ( inst_data_o[i]  ),
      .inst_error_o ( inst_error_o[i] ),
      .rsp_full_i   ( rsp_full        ),
      .req_valid_o  ( req_valid[i]    ),
      .gnt_i        ( gnt[i]          ),
      .rsp_valid_i  ( rsp_valid[i]    ),
      .rsp_line_i   ( rsp_line        ),
      .rsp_error_i  ( rsp_error       )
    );
  end

  fetch_rr_arbiter #(
    .NR_FETCH_PORTS ( NR_FETCH_PORTS ),
    .FETCH_AW       ( FETCH_AW       )
  ) i_arbiter (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .req_valid_i        ( req_valid          ),
    .req_addr_i         ( inst_addr_i        ),
    .gnt_o              ( gnt                ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .push_o             ( push               ),
    .push_mask_o        ( push_mask          )
  );

  refill_rsp_router #(
    .NR_FETCH_PORTS ( NR_FETCH_PORTS ),
    .RSP_FIFO_DEPTH ( RSP_FIFO_DEPTH )
  ) i_router (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .push_i             ( push               ),
    .push_mask_i        ( push_mask          ),
    .full_o             ( rsp_full           ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_data_i  ( refill_rsp_data_i  ),
    .refill_rsp_error_i ( refill_rsp_error_i ),
    .refill_rsp_ready_o ( refill_rsp_ready_o ),
    .rsp_valid_o        ( rsp_valid          ),
    .rsp_line_o         ( rsp_line           ),
    .rsp_error_o        ( rsp_error          )
  );

endmodule

`default_nettype wire

// File: verilog/refill_rsp_router.sv
// ========================================
// Refill response router
// Grant-order FIFO that steers each fill
// response back to its requesting port
// ========================================

`default_nettype none

module refill_rsp_router #(
  parameter int unsigned NR_FETCH_PORTS = 3,
  parameter int unsigned RSP_FIFO_DEPTH = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  // Grant record from the arbiter
  input  logic                                   push_i,
  input  logic [NR_FETCH_PORTS-1:0]              push_mask_i,
  output logic                                   full_o,

  // Fill response port
  input  logic                                   refill_rsp_valid_i,
  input  logic [icache_bypass_pkg::LINE_WIDTH-1:0] refill_rsp_data_i,
  input  logic                                   refill_rsp_error_i,
  output logic                                   refill_rsp_ready_o,

  // Towards the port FSMs
  output logic [NR_FETCH_PORTS-1:0]              rsp_valid_o,
  output icache_bypass_pkg::fill_line_u          rsp_line_o,
  output logic                                   rsp_error_o
);

  localparam int unsigned PTR_W = (RSP_FIFO_DEPTH > 1) ? $clog2(RSP_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(RSP_FIFO_DEPTH + 1);

  logic [NR_FETCH_PORTS-1:0] mask_mem [RSP_FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;
  logic                      empty;
  logic                      pop;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CNT_W'(RSP_FIFO_DEPTH));

  // Responses come back in request order, so the head always names a waiting port
  assign refill_rsp_ready_o = !empty;
  assign pop                = refill_rsp_valid_i && refill_rsp_ready_o;

  assign rsp_valid_o    = {NR_FETCH_PORTS{pop}} & mask_mem[rd_ptr_q];
  assign rsp_line_o.raw = refill_rsp_data_i;
  assign rsp_error_o    = refill_rsp_error_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mask_mem[wr_ptr_q] <= push_mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(RSP_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(RSP_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Ports stop requesting while full, so the arbiter never pushes then
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  // The fill side only answers refills that were actually issued
  a_no_rsp_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    refill_rsp_valid_i |-> !empty);

endmodule

`default_nettype wire
